/* rtl/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      strobe_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  localparam word_t RESET_PC    = '0;
  localparam word_t INSTR_BYTES = 32'd4;

  // major opcodes of the kept rv32i subset
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  localparam strobe_t WSTRB_NONE = 4'b0000;
  localparam strobe_t WSTRB_WORD = 4'b1111;

  typedef enum logic [3:0] {
    OP_ALU, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_ILLEGAL
  } op_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_fn_e;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    op_e       op;
    alu_fn_e   alu_fn;
    funct3_t   br_cond;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    word_t     pc;
    logic      use_imm;
  } decode_pkt_t;

  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    logic      we;
    word_t     result;
    word_t     addr;
    word_t     store_data;
    word_t     next_pc;
    logic      trap;
  } exec_pkt_t;

  typedef struct packed {
    reg_addr_t rd;
    logic      we;
    word_t     wdata;
    word_t     next_pc;
    logic      trap;
  } commit_pkt_t;

  // instr marks an instruction fetch on the memory port
  typedef struct packed {
    word_t   addr;
    word_t   wdata;
    strobe_t wstrb;
    logic    instr;
  } bus_req_t;

endpackage

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        commit_valid,
  input  commit_pkt_t commit,
  input  logic        bus_done,
  input  word_t       bus_rdata,
  output logic        fetch_go,
  output bus_req_t    fetch_req,
  output logic        fetch_valid,
  output fetch_pkt_t  fetch_pkt,
  output logic        trap
);

  word_t pc;
  logic  start;
  logic  fetching;

  // first fetch straight after reset, then one per retired instruction
  assign fetch_go  = start || (commit_valid && !commit.trap);
  assign fetch_req = '{addr: commit_valid ? commit.next_pc : pc, wdata: '0,
                       wstrb: WSTRB_NONE, instr: 1'b1};

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= RESET_PC;
      start       <= 1'b1;
      fetching    <= 1'b0;
      fetch_valid <= 1'b0;
      trap        <= 1'b0;
    end else begin
      start       <= 1'b0;
      fetch_valid <= 1'b0;
      if (fetch_go) begin
        fetching <= 1'b1;
      end
      if (commit_valid) begin
        if (commit.trap) begin
          trap <= 1'b1;
        end else begin
          pc <= commit.next_pc;
        end
      end
      if (bus_done && fetching) begin
        fetching    <= 1'b0;
        fetch_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_done && fetching) begin
      fetch_pkt <= '{pc: pc, instr: bus_rdata};
    end
  end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        fetch_valid,
  input  fetch_pkt_t  fetch_pkt,
  output reg_addr_t   rs1_addr,
  output reg_addr_t   rs2_addr,
  input  word_t       rs1_data,
  input  word_t       rs2_data,
  output logic        decode_valid,
  output decode_pkt_t decode_pkt
);

  word_t       instr;
  opcode_t     opcode;
  funct3_t     funct3;
  logic [6:0]  funct7;
  logic        alt;
  logic        reg_ok;
  logic        imm_ok;
  word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_fn_e     fn;
  decode_pkt_t pkt;

  assign instr    = fetch_pkt.instr;
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // instr[30] selects sub and sra, but addi never selects sub
  assign alt    = instr[30] && (opcode == OPC_OP || funct3 == 3'b101);
  assign reg_ok = funct7 == 7'b0 ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign imm_ok = (funct3 == 3'b001) ? funct7 == 7'b0 :
                  (funct3 == 3'b101) ? (funct7 == 7'b0 || funct7 == 7'b0100000) : 1'b1;

  always_comb begin
    case (funct3)
      3'b000:  fn = alt ? ALU_SUB : ALU_ADD;
      3'b001:  fn = ALU_SLL;
      3'b010:  fn = ALU_SLT;
      3'b011:  fn = ALU_SLTU;
      3'b100:  fn = ALU_XOR;
      3'b101:  fn = alt ? ALU_SRA : ALU_SRL;
      3'b110:  fn = ALU_OR;
      default: fn = ALU_AND;
    endcase
  end

  always_comb begin
    pkt = '{op: OP_ILLEGAL, alu_fn: fn, br_cond: funct3, rd: instr[11:7], rs1_val: rs1_data,
            rs2_val: rs2_data, imm: imm_i, pc: fetch_pkt.pc, use_imm: opcode == OPC_OP_IMM};
    case (opcode)
      OPC_LUI:    pkt.op = OP_LUI;
      OPC_AUIPC:  pkt.op = OP_AUIPC;
      OPC_JAL:    pkt.op = OP_JAL;
      OPC_JALR:   pkt.op = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
      OPC_BRANCH: pkt.op = (funct3[2:1] == 2'b01) ? OP_ILLEGAL : OP_BRANCH;
      OPC_LOAD:   pkt.op = (funct3 == 3'b010) ? OP_LOAD : OP_ILLEGAL;
      OPC_STORE:  pkt.op = (funct3 == 3'b010) ? OP_STORE : OP_ILLEGAL;
      OPC_OP_IMM: pkt.op = imm_ok ? OP_ALU : OP_ILLEGAL;
      OPC_OP:     pkt.op = reg_ok ? OP_ALU : OP_ILLEGAL;
      default:    pkt.op = OP_ILLEGAL;
    endcase
    case (opcode)
      OPC_LUI, OPC_AUIPC: pkt.imm = imm_u;
      OPC_JAL:            pkt.imm = imm_j;
      OPC_BRANCH:         pkt.imm = imm_b;
      OPC_STORE:          pkt.imm = imm_s;
      default:            pkt.imm = imm_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decode_valid <= 1'b0;
    end else begin
      decode_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      decode_pkt <= pkt;
    end
  end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      write_en,
  input  reg_addr_t write_addr,
  input  word_t     write_data
);

  word_t regs [REG_COUNT];

  // x0 is never written and always reads back as zero
  always_ff @(posedge clk) begin
    if (write_en && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        decode_valid,
  input  decode_pkt_t decode_pkt,
  output logic        exec_valid,
  output exec_pkt_t   exec_pkt
);

  decode_pkt_t d;
  word_t       operand_b;
  logic [4:0]  shamt;
  word_t       alu_out;
  word_t       link;
  word_t       mem_addr;
  logic        taken;
  exec_pkt_t   pkt;

  assign d         = decode_pkt;
  assign operand_b = d.use_imm ? d.imm : d.rs2_val;
  assign shamt     = operand_b[4:0];
  assign link      = d.pc + INSTR_BYTES;
  assign mem_addr  = d.rs1_val + d.imm;

  always_comb begin
    case (d.alu_fn)
      ALU_ADD:  alu_out = d.rs1_val + operand_b;
      ALU_SUB:  alu_out = d.rs1_val - operand_b;
      ALU_SLL:  alu_out = d.rs1_val << shamt;
      ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(d.rs1_val) < $signed(operand_b)};
      ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, d.rs1_val < operand_b};
      ALU_XOR:  alu_out = d.rs1_val ^ operand_b;
      ALU_SRL:  alu_out = d.rs1_val >> shamt;
      ALU_SRA:  alu_out = word_t'($signed(d.rs1_val) >>> shamt);
      ALU_OR:   alu_out = d.rs1_val | operand_b;
      default:  alu_out = d.rs1_val & operand_b;
    endcase
  end

  // funct3 of the branch picks the compare
  always_comb begin
    case (d.br_cond)
      3'b000:  taken = d.rs1_val == d.rs2_val;
      3'b001:  taken = d.rs1_val != d.rs2_val;
      3'b100:  taken = $signed(d.rs1_val) < $signed(d.rs2_val);
      3'b101:  taken = $signed(d.rs1_val) >= $signed(d.rs2_val);
      3'b110:  taken = d.rs1_val < d.rs2_val;
      default: taken = d.rs1_val >= d.rs2_val;
    endcase
  end

  always_comb begin
    pkt = '{op: d.op, rd: d.rd, we: 1'b1, result: alu_out, addr: mem_addr,
            store_data: d.rs2_val, next_pc: link, trap: 1'b0};
    case (d.op)
      OP_LUI:    pkt.result = d.imm;
      OP_AUIPC:  pkt.result = d.pc + d.imm;
      OP_JAL:    {pkt.result, pkt.next_pc} = {link, d.pc + d.imm};
      OP_JALR:   {pkt.result, pkt.next_pc} = {link, mem_addr & ~word_t'(1)};
      OP_BRANCH: {pkt.we, pkt.next_pc} = {1'b0, taken ? d.pc + d.imm : link};
      OP_STORE:  pkt.we = 1'b0;
      default:   ;
    endcase
    pkt.trap = d.op == OP_ILLEGAL || pkt.next_pc[1] ||
               ((d.op == OP_LOAD || d.op == OP_STORE) && mem_addr[1:0] != 2'b00);
    pkt.we = pkt.we && !pkt.trap;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exec_valid <= 1'b0;
    end else begin
      exec_valid <= decode_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (decode_valid) begin
      exec_pkt <= pkt;
    end
  end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        exec_valid,
  input  exec_pkt_t   exec_pkt,
  output logic        data_go,
  output bus_req_t    data_req,
  input  logic        bus_done,
  input  word_t       bus_rdata,
  output logic        commit_valid,
  output commit_pkt_t commit
);

  typedef enum logic [1:0] {MEM_IDLE, MEM_ISSUE, MEM_WAIT} mem_state_e;

  mem_state_e state;
  exec_pkt_t  ex_q;
  logic       is_mem;

  assign is_mem   = (exec_pkt.op == OP_LOAD || exec_pkt.op == OP_STORE) && !exec_pkt.trap;
  assign data_go  = state == MEM_ISSUE;
  assign data_req = '{addr: ex_q.addr, wdata: ex_q.store_data,
                      wstrb: (ex_q.op == OP_STORE) ? WSTRB_WORD : WSTRB_NONE, instr: 1'b0};

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= MEM_IDLE;
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= 1'b0;
      case (state)
        MEM_IDLE: begin
          if (exec_valid) begin
            state        <= is_mem ? MEM_ISSUE : MEM_IDLE;
            commit_valid <= !is_mem;
          end
        end
        MEM_ISSUE: state <= MEM_WAIT;
        default: begin
          if (bus_done) begin
            state        <= MEM_IDLE;
            commit_valid <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (exec_valid) begin
      ex_q   <= exec_pkt;
      commit <= '{rd: exec_pkt.rd, we: exec_pkt.we, wdata: exec_pkt.result,
                  next_pc: exec_pkt.next_pc, trap: exec_pkt.trap};
    end else if (bus_done && state == MEM_WAIT && ex_q.op == OP_LOAD) begin
      commit.wdata <= bus_rdata;
    end
  end

endmodule

/* rtl/bus_port.sv */
`timescale 1ns/1ps

module bus_port import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     fetch_go,
  input  bus_req_t fetch_req,
  input  logic     data_go,
  input  bus_req_t data_req,
  output logic     bus_done,
  output word_t    bus_rdata,
  output logic     mem_valid,
  output logic     mem_instr,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output strobe_t  mem_wstrb,
  input  logic     mem_ready,
  input  word_t    mem_rdata
);

  bus_req_t req_q;
  logic     start;

  assign start = !mem_valid && (fetch_go || data_go);

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
    end else if (mem_valid && mem_ready) begin
      mem_valid <= 1'b0;
    end else if (start) begin
      mem_valid <= 1'b1;
    end
  end

  // request stays frozen until the handshake
  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= fetch_go ? fetch_req : data_req;
    end
  end

  assign mem_addr  = req_q.addr;
  assign mem_wdata = req_q.wdata;
  assign mem_wstrb = req_q.wstrb;
  assign mem_instr = req_q.instr;
  assign bus_done  = mem_valid && mem_ready;
  assign bus_rdata = mem_rdata;

endmodule

/* rtl/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core import rv_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  output logic    mem_valid,
  output logic    mem_instr,
  output word_t   mem_addr,
  output word_t   mem_wdata,
  output strobe_t mem_wstrb,
  output logic    trap,
  input  logic    mem_ready,
  input  word_t   mem_rdata
);

  logic        fetch_go, data_go, bus_done;
  bus_req_t    fetch_req, data_req;
  word_t       bus_rdata;
  logic        fetch_valid, decode_valid, exec_valid, commit_valid;
  fetch_pkt_t  fetch_pkt;
  decode_pkt_t decode_pkt;
  exec_pkt_t   exec_pkt;
  commit_pkt_t commit;
  reg_addr_t   rs1_addr, rs2_addr;
  word_t       rs1_data, rs2_data;

  fetch_stage fetch0 (.clk, .reset, .commit_valid, .commit, .bus_done, .bus_rdata,
                      .fetch_go, .fetch_req, .fetch_valid, .fetch_pkt, .trap);

  decode_stage decode0 (.clk, .reset, .fetch_valid, .fetch_pkt, .rs1_addr, .rs2_addr,
                        .rs1_data, .rs2_data, .decode_valid, .decode_pkt);

  register_file regs0 (.clk, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
                       .write_en(commit_valid && commit.we), .write_addr(commit.rd),
                       .write_data(commit.wdata));

  execute_stage exec0 (.clk, .reset, .decode_valid, .decode_pkt, .exec_valid, .exec_pkt);

  mem_stage mem0 (.clk, .reset, .exec_valid, .exec_pkt, .data_go, .data_req, .bus_done,
                  .bus_rdata, .commit_valid, .commit);

  // single memory port shared by fetch and load/store
  bus_port bus0 (.clk, .reset, .fetch_go, .fetch_req, .data_go, .data_req, .bus_done,
                 .bus_rdata, .mem_valid, .mem_instr, .mem_addr, .mem_wdata, .mem_wstrb,
                 .mem_ready, .mem_rdata);

endmodule

/* verification/tb_ref_model.svh */
// instruction-set model state that advances one instruction per fetch
logic [31:0] ref_pc;
logic [31:0] ref_regs [32];
logic [31:0] ref_mem [512];
int          exp_state;
req_t        exp_req;

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'd0, $signed(a) < $signed(b)};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic void ref_step();
  logic [31:0] ins, a, b, imm_i, imm_s, nxt, res, ea;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic        legal, wr, tk, is_load, is_store;
  ins = ref_mem[ref_pc[10:2]];
  f3 = ins[14:12];
  rd = ins[11:7];
  a = ref_regs[ins[19:15]];
  b = ref_regs[ins[24:20]];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  nxt = ref_pc + 32'd4;
  res = 32'd0;
  ea = a + imm_i;
  legal = 1'b1;
  wr = 1'b1;
  tk = 1'b0;
  is_load = ins[6:0] == 7'h03;
  is_store = ins[6:0] == 7'h23;
  case (ins[6:0])
    7'h37: res = {ins[31:12], 12'b0};
    7'h17: res = ref_pc + {ins[31:12], 12'b0};
    7'h6f: begin
      res = nxt;
      nxt = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    7'h67: begin
      legal = f3 == 3'd0;
      res = nxt;
      nxt = (a + imm_i) & 32'hffff_fffe;
    end
    7'h63: begin
      wr = 1'b0;
      legal = f3[2:1] != 2'b01;
      case (f3)
        3'd0: tk = a == b;
        3'd1: tk = a != b;
        3'd4: tk = $signed(a) < $signed(b);
        3'd5: tk = $signed(a) >= $signed(b);
        3'd6: tk = a < b;
        default: tk = a >= b;
      endcase
      if (tk) nxt = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    end
    7'h03: legal = f3 == 3'd2;
    7'h23: begin
      wr = 1'b0;
      legal = f3 == 3'd2;
      ea = a + imm_s;
    end
    7'h13: begin
      if (f3 == 3'd1) legal = ins[31:25] == 7'h00;
      if (f3 == 3'd5) legal = ins[31:25] == 7'h00 || ins[31:25] == 7'h20;
      res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
    end
    7'h33: begin
      legal = ins[31:25] == 7'h00 || (ins[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      res = alu_ref(f3, ins[30], a, b);
    end
    default: legal = 1'b0;
  endcase
  if (!legal || nxt[1] || ((is_load || is_store) && ea[1:0] != 2'b00)) begin
    exp_state = ST_TRAP;
    return;
  end
  exp_state = ST_FETCH;
  if (is_load) begin
    exp_req = '{addr: ea, wdata: 32'd0, wstrb: 4'h0, instr: 1'b0};
    res = ref_mem[ea[10:2]];
    exp_state = ST_DATA;
  end else if (is_store) begin
    exp_req = '{addr: ea, wdata: b, wstrb: 4'hf, instr: 1'b0};
    ref_mem[ea[10:2]] = b;
    exp_state = ST_DATA;
  end
  if (wr && rd != 5'd0) ref_regs[rd] = res;
  ref_pc = nxt;
endfunction

function automatic void fill_image();
  for (int i = 0; i < 512; i++) begin
    image[i] = {~16'(i), 16'(i)};
  end
endfunction

// random program made of register init, a random body with forward jumps and a register dump
function automatic void build_program();
  int          k;
  int          lim;
  logic [4:0]  rd, rs1, rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [20:0] off;
  fill_image();
  for (int r = 1; r < 32; r++) begin
    image[r - 1] = {12'($urandom), 5'd0, 3'd0, 5'(r), 7'h13};
  end
  for (int pc_w = 31; pc_w < 31 + RAND_LEN; pc_w++) begin
    lim = 31 + RAND_LEN - pc_w;
    k = 1 + int'($urandom % 32'((lim < 4) ? lim : 4));
    off = 21'(4 * k);
    rd = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    f3 = 3'($urandom);
    imm = 12'($urandom);
    case ($urandom % 8)
      0, 1: image[pc_w] = {((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
                           rs2, rs1, f3, rd, 7'h33};
      2, 3: begin
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'd0};
        image[pc_w] = {imm, rs1, f3, rd, 7'h13};
      end
      4: image[pc_w] = {20'($urandom), rd, imm[0] ? 7'h37 : 7'h17};
      5: begin
        // funct3 2 and 3 are not branches
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        image[pc_w] = {off[12], off[10:5], imm[1] ? rs1 : rs2, rs1, f3, off[4:1], off[11],
                       7'h63};
      end
      6: begin
        if (imm[0]) image[pc_w] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
        else image[pc_w] = {12'(4 * (pc_w + k)) | {11'd0, imm[1]}, 5'd0, 3'd0, rd, 7'h67};
      end
      default: begin
        imm = 12'(32'h600 + 4 * ($urandom % 64));
        if (f3[0]) image[pc_w] = {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
        else image[pc_w] = {imm, 5'd0, 3'd2, rd, 7'h03};
      end
    endcase
  end
  for (int r = 0; r < 32; r++) begin
    imm = 12'(32'h700 + 4 * r);
    image[31 + RAND_LEN + r] = {imm[11:5], 5'(r), 5'd0, 3'd2, imm[4:0], 7'h23};
  end
  image[31 + RAND_LEN + 32] = 32'd0;
endfunction

// two-word programs that end in one particular trap
function automatic void build_trap_program(int kind);
  fill_image();
  image[0] = {12'h602, 5'd0, 3'd0, 5'd1, 7'h13};
  case (kind)
    0: image[1] = 32'hffff_ffff;
    // sw x1, 0(x1) on an address ending in 2
    1: image[1] = {7'd0, 5'd1, 5'd1, 3'd2, 5'd0, 7'h23};
    // jal x1 to pc+6
    default: image[1] = {1'b0, 10'd3, 1'b0, 8'd0, 5'd1, 7'h6f};
  endcase
endfunction

/* verification/tb_riscv_core.sv */
`timescale 1ns/1ps

module tb_riscv_core;

  localparam int          RAND_LEN    = 60;
  localparam int          PROG_WORDS  = 31 + RAND_LEN + 33;
  localparam int          RUNS        = 5;
  localparam int          STALL_WORST = 4;
  localparam logic [31:0] SEED        = 32'he07c26ed;
  localparam int          ST_FETCH    = 0;
  localparam int          ST_DATA     = 1;
  localparam int          ST_TRAP     = 2;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        instr;
  } req_t;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        mem_ready = 1'b0;
  logic [31:0] mem_rdata = 32'd0;
  logic        mem_valid, mem_instr, trap;
  logic [31:0] mem_addr, mem_wdata;
  logic [3:0]  mem_wstrb;

  logic [31:0] mem [512];
  logic [31:0] image [512];
  logic        stall_on = 1'b1;
  logic        trap_seen = 1'b0;
  logic        hold_valid = 1'b0;
  req_t        held_req;

  `include "tb_ref_model.svh"

  riscv_core dut0 (.clk, .reset, .mem_valid, .mem_instr, .mem_addr, .mem_wdata, .mem_wstrb,
                   .trap, .mem_ready, .mem_rdata);

  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_problem(string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  // memory model with at least one wait cycle and random stalls after it
  always @(posedge clk) begin
    if (reset) begin
      mem = image;
      mem_ready <= 1'b0;
    end else if (mem_valid && mem_ready) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) mem[mem_addr[10:2]][8*b +: 8] = mem_wdata[8*b +: 8];
      end
      mem_ready <= 1'b0;
    end else if (mem_valid) begin
      mem_ready <= stall_on ? ($urandom % 4 != 0) : 1'b1;
      mem_rdata <= mem[mem_addr[10:2]];
    end else begin
      mem_ready <= 1'b0;
    end
  end

  task automatic check_request();
    case (exp_state)
      ST_FETCH: begin
        assert (mem_instr) else report_mismatch("mem_instr", 32'(mem_instr), 32'd1);
        assert (mem_addr == ref_pc) else report_mismatch("mem_addr", mem_addr, ref_pc);
        assert (mem_wstrb == 4'h0) else report_mismatch("mem_wstrb", 32'(mem_wstrb), 32'd0);
        ref_step();
      end
      ST_DATA: begin
        assert (!mem_instr) else report_mismatch("mem_instr", 32'(mem_instr), 32'd0);
        assert (mem_addr == exp_req.addr)
          else report_mismatch("mem_addr", mem_addr, exp_req.addr);
        assert (mem_wstrb == exp_req.wstrb)
          else report_mismatch("mem_wstrb", 32'(mem_wstrb), 32'(exp_req.wstrb));
        if (exp_req.wstrb != 4'h0) begin
          assert (mem_wdata == exp_req.wdata)
            else report_mismatch("mem_wdata", mem_wdata, exp_req.wdata);
        end
        exp_state = ST_FETCH;
      end
      default: report_problem("a memory request was issued past the trapping instruction");
    endcase
  endtask

  // compares every handshake against the reference and watches request stability
  always @(posedge clk) begin
    if (reset) begin
      ref_mem = image;
      ref_regs = '{default: 32'd0};
      ref_pc = 32'd0;
      exp_state = ST_FETCH;
      trap_seen = 1'b0;
      hold_valid = 1'b0;
    end else begin
      if (trap_seen) begin
        assert (trap) else report_mismatch("trap", 32'(trap), 32'd1);
        assert (!mem_valid) else report_problem("a memory request was issued after the trap");
      end else if (trap) begin
        assert (exp_state == ST_TRAP)
          else report_problem("trap rose although none was expected");
        trap_seen = 1'b1;
      end
      if (hold_valid) begin
        assert (mem_valid) else report_mismatch("mem_valid", 32'(mem_valid), 32'd1);
        assert (mem_addr == held_req.addr)
          else report_mismatch("mem_addr", mem_addr, held_req.addr);
        assert (mem_wdata == held_req.wdata)
          else report_mismatch("mem_wdata", mem_wdata, held_req.wdata);
        assert (mem_wstrb == held_req.wstrb)
          else report_mismatch("mem_wstrb", 32'(mem_wstrb), 32'(held_req.wstrb));
        assert (mem_instr == held_req.instr)
          else report_mismatch("mem_instr", 32'(mem_instr), 32'(held_req.instr));
      end
      hold_valid = mem_valid && !mem_ready;
      held_req = '{addr: mem_addr, wdata: mem_wdata, wstrb: mem_wstrb, instr: mem_instr};
      if (mem_valid && mem_ready) check_request();
    end
  end

  task automatic run_program(input logic stalls);
    @(posedge clk);
    reset <= 1'b1;
    stall_on = stalls;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    wait (trap_seen);
    // the core must stay silent after the trap
    repeat (10) @(posedge clk);
    for (int i = 0; i < 512; i++) begin
      assert (mem[i] == ref_mem[i])
        else report_mismatch($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    build_program();
    run_program(1'b1);
    run_program(1'b0);
    for (int kind = 0; kind < 3; kind++) begin
      build_trap_program(kind);
      run_program(1'b1);
    end
    $display("Test passed");
    $finish;
  end

  initial begin
    #(RUNS * PROG_WORDS * 40 * STALL_WORST * 100);
    report_problem("watchdog expired before all runs reached their trap");
  end

endmodule

/* project.f */
+incdir+verification
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/bus_port.sv
rtl/riscv_core.sv
verification/tb_riscv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(wildcard rtl/*.sv verification/*.sv verification/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
